// ==== hdl/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int addr_w  = 32;
    localparam int word_w  = 32;
    localparam int strb_w  = word_w / 8;
    // burst length field holds beats minus one
    localparam int beats_w = 2;

    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [word_w-1:0]  word_t;
    typedef logic [strb_w-1:0]  strb_t;
    typedef logic [beats_w-1:0] len_t;

    // every byte lane enabled, used for line writebacks
    localparam strb_t strb_full = '1;

    localparam len_t len_single = '0;

    // owner codes of the shared bus
    localparam logic owner_fill = 1'b0;
    localparam logic owner_wb   = 1'b1;

endpackage

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    localparam int line_words = 4;
    localparam int num_lines  = 16;

    localparam int byte_sel_w = 2;
    localparam int word_sel_w = 2;
    localparam int offset_w   = word_sel_w + byte_sel_w;
    localparam int index_w    = 4;
    localparam int tag_w      = mem_bus_pkg::addr_w - index_w - offset_w;

    typedef logic [tag_w-1:0]      tag_t;
    typedef logic [index_w-1:0]    index_t;
    typedef logic [word_sel_w-1:0] word_sel_t;
    typedef mem_bus_pkg::word_t [line_words-1:0] line_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        UNC_WAIT,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== hdl/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;
    import mem_bus_pkg::*;

    logic  req;
    logic  we;
    addr_t addr;
    len_t  len;
    word_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wlast;

    // responses, routed back by the arbiter
    logic  gnt_rdy;
    logic  rvalid;
    word_t rdata;
    logic  rlast;
    logic  bvalid;

    modport agent (
        output req, we, addr, len, wdata, wstrb, wvalid, wlast,
        input  gnt_rdy, rvalid, rdata, rlast, bvalid
    );

    modport arbiter (
        input  req, we, addr, len, wdata, wstrb, wvalid, wlast,
        output gnt_rdy, rvalid, rdata, rlast, bvalid
    );

endinterface

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                clk,
    input  logic                arst_n,
    mem_bus_if.arbiter          fill_bus,
    mem_bus_if.arbiter          wb_bus,
    output logic                mem_req,
    output logic                mem_we,
    output mem_bus_pkg::addr_t  mem_addr,
    output mem_bus_pkg::len_t   mem_len,
    output logic                mem_wvalid,
    output mem_bus_pkg::word_t  mem_wdata,
    output mem_bus_pkg::strb_t  mem_wstrb,
    output logic                mem_wlast,
    output logic                mem_bready,
    input  logic                mem_rdy,
    input  logic                mem_rvalid,
    input  mem_bus_pkg::word_t  mem_rdata,
    input  logic                mem_rlast,
    input  logic                mem_bvalid
);
    import mem_bus_pkg::*;

    logic open_q, accepted_q, owner_q, we_q, wdone_q;
    logic cur, accept, xfer_done;

    // writer wins when the bus is idle, otherwise the locked owner
    assign cur = open_q ? owner_q : (wb_bus.req ? owner_wb : owner_fill);

    assign mem_req  = !accepted_q && (cur == owner_wb ? wb_bus.req : fill_bus.req);
    assign mem_we   = cur == owner_wb ? wb_bus.we : fill_bus.we;
    assign mem_addr = cur == owner_wb ? wb_bus.addr : fill_bus.addr;
    assign mem_len  = cur == owner_wb ? wb_bus.len : fill_bus.len;

    assign mem_wvalid = accepted_q && (cur == owner_wb ? wb_bus.wvalid : fill_bus.wvalid);
    assign mem_wdata  = cur == owner_wb ? wb_bus.wdata : fill_bus.wdata;
    assign mem_wstrb  = cur == owner_wb ? wb_bus.wstrb : fill_bus.wstrb;
    assign mem_wlast  = cur == owner_wb ? wb_bus.wlast : fill_bus.wlast;
    assign mem_bready = accepted_q && we_q && wdone_q;

    assign accept    = mem_req && mem_rdy;
    assign xfer_done = accepted_q && (we_q ? mem_bvalid : (mem_rvalid && mem_rlast));

    // responses go to the owner only
    assign fill_bus.gnt_rdy = accept && cur == owner_fill;
    assign fill_bus.rvalid  = accepted_q && owner_q == owner_fill && mem_rvalid;
    assign fill_bus.rlast   = accepted_q && owner_q == owner_fill && mem_rlast;
    assign fill_bus.bvalid  = accepted_q && owner_q == owner_fill && mem_bvalid;
    assign fill_bus.rdata   = mem_rdata;
    assign wb_bus.gnt_rdy   = accept && cur == owner_wb;
    assign wb_bus.rvalid    = accepted_q && owner_q == owner_wb && mem_rvalid;
    assign wb_bus.rlast     = accepted_q && owner_q == owner_wb && mem_rlast;
    assign wb_bus.bvalid    = accepted_q && owner_q == owner_wb && mem_bvalid;
    assign wb_bus.rdata     = mem_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            open_q     <= 1'b0;
            accepted_q <= 1'b0;
            owner_q    <= owner_fill;
            we_q       <= 1'b0;
            wdone_q    <= 1'b0;
        end else if (xfer_done) begin
            open_q     <= 1'b0;
            accepted_q <= 1'b0;
            wdone_q    <= 1'b0;
        end else begin
            if (mem_req && !open_q) begin
                open_q  <= 1'b1;
                owner_q <= cur;
            end
            if (accept) begin
                accepted_q <= 1'b1;
                we_q       <= mem_we;
            end
            if (mem_wvalid && mem_wlast)
                wdone_q <= 1'b1;
        end
    end

    owner_locked: assert property (@(posedge clk) disable iff (!arst_n)
        open_q && !xfer_done |=> open_q && $stable(owner_q));

endmodule

// ==== hdl/line_fill_unit.sv ====
`timescale 1ns/1ps

module line_fill_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic               uncached,
    input  mem_bus_pkg::addr_t addr,
    output logic               done,
    output dcache_pkg::line_t  line,
    mem_bus_if.agent           bus
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    logic      req_q, out_q, uncached_q, done_q;
    addr_t     addr_q;
    word_sel_t beat_q;
    line_t     line_q;

    assign bus.req    = req_q;
    assign bus.we     = 1'b0;
    assign bus.addr   = addr_q;
    assign bus.len    = uncached_q ? len_single : len_t'(line_words - 1);
    assign bus.wdata  = '0;
    assign bus.wstrb  = '0;
    assign bus.wvalid = 1'b0;
    assign bus.wlast  = 1'b0;

    assign done = done_q;
    assign line = line_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q  <= 1'b0;
            out_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= out_q && bus.rvalid && bus.rlast;
            if (start)
                req_q <= 1'b1;
            else if (req_q && bus.gnt_rdy)
                req_q <= 1'b0;
            if (req_q && bus.gnt_rdy)
                out_q <= 1'b1;
            else if (bus.rvalid && bus.rlast)
                out_q <= 1'b0;
        end
    end

    // uncached word lands at its own slot of the line
    always_ff @(posedge clk) begin
        if (start) begin
            uncached_q <= uncached;
            addr_q <= uncached ? {addr[addr_w-1:byte_sel_w], byte_sel_w'(0)}
                               : {addr[addr_w-1:offset_w], offset_w'(0)};
            beat_q <= uncached ? addr[offset_w-1:byte_sel_w] : '0;
        end else if (bus.rvalid) begin
            line_q[beat_q] <= bus.rdata;
            beat_q <= beat_q + 1'b1;
        end
    end

    rvalid_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        bus.rvalid |-> out_q);

endmodule

// ==== hdl/victim_writer.sv ====
`timescale 1ns/1ps

module victim_writer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic               uncached,
    input  mem_bus_pkg::addr_t addr,
    input  dcache_pkg::line_t  line,
    input  mem_bus_pkg::strb_t strb,
    output logic               done,
    mem_bus_if.agent           bus
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    logic      req_q, stream_q, wait_b_q, uncached_q, done_q;
    addr_t     addr_q;
    strb_t     strb_q;
    line_t     line_q;
    word_sel_t beat_q;
    len_t      left_q;

    assign bus.req    = req_q;
    assign bus.we     = 1'b1;
    assign bus.addr   = addr_q;
    assign bus.len    = uncached_q ? len_single : len_t'(line_words - 1);
    assign bus.wdata  = line_q[beat_q];
    assign bus.wstrb  = strb_q;
    assign bus.wvalid = stream_q;
    assign bus.wlast  = stream_q && left_q == '0;

    assign done = done_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q    <= 1'b0;
            stream_q <= 1'b0;
            wait_b_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= wait_b_q && bus.bvalid;
            if (start)
                req_q <= 1'b1;
            else if (req_q && bus.gnt_rdy)
                req_q <= 1'b0;
            // beats start the cycle after acceptance
            if (req_q && bus.gnt_rdy)
                stream_q <= 1'b1;
            else if (bus.wlast)
                stream_q <= 1'b0;
            if (bus.wlast)
                wait_b_q <= 1'b1;
            else if (bus.bvalid)
                wait_b_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            uncached_q <= uncached;
            addr_q <= uncached ? addr : {addr[addr_w-1:offset_w], offset_w'(0)};
            strb_q <= uncached ? strb : strb_full;
            line_q <= line;
            beat_q <= uncached ? addr[offset_w-1:byte_sel_w] : '0;
            left_q <= uncached ? len_single : len_t'(line_words - 1);
        end else if (stream_q) begin
            beat_q <= beat_q + 1'b1;
            left_q <= left_q - 1'b1;
        end
    end

endmodule

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               valid,
    input  logic               op,
    input  logic               uncache,
    input  mem_bus_pkg::addr_t addr,
    input  mem_bus_pkg::strb_t wstrb,
    input  mem_bus_pkg::word_t wdata,
    output logic               ready,
    output logic               data_valid,
    output mem_bus_pkg::word_t rdata,
    output logic               fill_start,
    output logic               fill_uncached,
    output mem_bus_pkg::addr_t fill_addr,
    input  logic               fill_done,
    input  dcache_pkg::line_t  fill_line,
    output logic               wb_start,
    output logic               wb_uncached,
    output mem_bus_pkg::addr_t wb_addr,
    output dcache_pkg::line_t  wb_line,
    output mem_bus_pkg::strb_t wb_strb,
    input  logic               wb_done
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    tag_t  tag_arr  [num_lines];
    line_t data_arr [num_lines];
    logic [num_lines-1:0] valid_bits, dirty_bits;

    ctrl_state_t state_q;
    logic        op_q, unc_q;
    addr_t       addr_q;
    strb_t       strb_q;
    word_t       wdata_q, rdata_q;

    index_t    idx;
    tag_t      tag;
    word_sel_t wsel;
    logic      hit, victim_dirty, accept;

    function automatic line_t merge(line_t old, word_sel_t sel, strb_t be, word_t din);
        line_t res;
        res = old;
        for (int b = 0; b < strb_w; b++) begin
            if (be[b])
                res[sel][b*8 +: 8] = din[b*8 +: 8];
        end
        return res;
    endfunction

    assign idx  = addr_q[offset_w +: index_w];
    assign tag  = addr_q[addr_w-1 -: tag_w];
    assign wsel = addr_q[offset_w-1:byte_sel_w];

    assign hit          = valid_bits[idx] && tag_arr[idx] == tag;
    assign victim_dirty = valid_bits[idx] && dirty_bits[idx];

    // RESPOND doubles as an accepting cycle
    assign ready      = state_q == IDLE || state_q == RESPOND;
    assign data_valid = state_q == RESPOND;
    assign rdata      = rdata_q;
    assign accept     = valid && ready;

    assign fill_start = (state_q == LOOKUP && !op_q && unc_q)
                      || (state_q == LOOKUP && !unc_q && !hit && !victim_dirty)
                      || (state_q == MISS && wb_done);
    assign wb_start   = (state_q == LOOKUP && op_q && unc_q)
                      || (state_q == LOOKUP && !unc_q && !hit && victim_dirty);

    assign fill_uncached = unc_q;
    assign fill_addr     = addr_q;
    assign wb_uncached   = unc_q;
    assign wb_addr   = unc_q ? addr_q : {tag_arr[idx], idx, offset_w'(0)};
    assign wb_line   = unc_q ? {line_words{wdata_q}} : data_arr[idx];
    assign wb_strb   = strb_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op;
            unc_q   <= uncache;
            addr_q  <= addr;
            strb_q  <= wstrb;
            wdata_q <= wdata;
        end
        if (state_q == LOOKUP && !unc_q && hit) begin
            rdata_q <= data_arr[idx][wsel];
            if (op_q)
                data_arr[idx] <= merge(data_arr[idx], wsel, strb_q, wdata_q);
        end
        // install the refilled line with any pending store bytes
        if (state_q == REFILL && fill_done) begin
            rdata_q       <= fill_line[wsel];
            tag_arr[idx]  <= tag;
            data_arr[idx] <= merge(fill_line, wsel, op_q ? strb_q : '0, wdata_q);
        end
        if (state_q == UNC_WAIT && fill_done)
            rdata_q <= fill_line[wsel];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= IDLE;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            case (state_q)
                IDLE, RESPOND: state_q <= accept ? LOOKUP : IDLE;
                LOOKUP: begin
                    if (unc_q)
                        state_q <= UNC_WAIT;
                    else if (hit) begin
                        state_q <= RESPOND;
                        if (op_q)
                            dirty_bits[idx] <= 1'b1;
                    end else
                        state_q <= victim_dirty ? MISS : REFILL;
                end
                MISS: if (wb_done) state_q <= REFILL;
                REFILL: begin
                    if (fill_done) begin
                        state_q         <= RESPOND;
                        valid_bits[idx] <= 1'b1;
                        dirty_bits[idx] <= op_q;
                    end
                end
                UNC_WAIT: if (fill_done || wb_done) state_q <= RESPOND;
                default: state_q <= IDLE;
            endcase
        end
    end

    ready_only_with_data: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ready) |-> data_valid);

    one_agent_start: assert property (@(posedge clk) disable iff (!arst_n)
        !(fill_start && wb_start));

endmodule

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               valid,
    input  logic               op,
    input  logic               uncache,
    input  mem_bus_pkg::addr_t addr,
    input  mem_bus_pkg::strb_t wstrb,
    input  mem_bus_pkg::word_t wdata,
    output logic               ready,
    output logic               data_valid,
    output mem_bus_pkg::word_t rdata,
    output logic               mem_req,
    output logic               mem_we,
    output mem_bus_pkg::addr_t mem_addr,
    output mem_bus_pkg::len_t  mem_len,
    input  logic               mem_rdy,
    input  logic               mem_rvalid,
    input  mem_bus_pkg::word_t mem_rdata,
    input  logic               mem_rlast,
    output logic               mem_wvalid,
    output mem_bus_pkg::word_t mem_wdata,
    output mem_bus_pkg::strb_t mem_wstrb,
    output logic               mem_wlast,
    output logic               mem_bready,
    input  logic               mem_bvalid
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    logic  fill_start, fill_uncached, fill_done;
    logic  wb_start, wb_uncached, wb_done;
    addr_t fill_addr, wb_addr;
    line_t fill_line, wb_line;
    strb_t wb_strb;

    mem_bus_if fill_bus ();
    mem_bus_if wb_bus ();

    dcache_ctrl u_ctrl (.*);

    line_fill_unit u_fill (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (fill_start),
        .uncached (fill_uncached),
        .addr     (fill_addr),
        .done     (fill_done),
        .line     (fill_line),
        .bus      (fill_bus.agent)
    );

    victim_writer u_wb (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (wb_start),
        .uncached (wb_uncached),
        .addr     (wb_addr),
        .line     (wb_line),
        .strb     (wb_strb),
        .done     (wb_done),
        .bus      (wb_bus.agent)
    );

    bus_arbiter u_arb (
        .fill_bus (fill_bus.arbiter),
        .wb_bus   (wb_bus.arbiter),
        .*
    );

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               mem_req,
    input  logic               mem_we,
    input  mem_bus_pkg::addr_t mem_addr,
    input  mem_bus_pkg::len_t  mem_len,
    output logic               mem_rdy,
    output logic               mem_rvalid,
    output mem_bus_pkg::word_t mem_rdata,
    output logic               mem_rlast,
    input  logic               mem_wvalid,
    input  mem_bus_pkg::word_t mem_wdata,
    input  mem_bus_pkg::strb_t mem_wstrb,
    input  logic               mem_wlast,
    input  logic               mem_bready,
    output logic               mem_bvalid
);
    import mem_bus_pkg::*;

    localparam int mem_words = 4096;
    localparam int log_depth = 1024;

    word_t mem [mem_words];

    // transaction and write beat logs for the testbench
    addr_t log_addr [log_depth];
    logic  log_we   [log_depth];
    len_t  log_len  [log_depth];
    word_t beat_data [log_depth];
    strb_t beat_strb [log_depth];
    int    n_txn, n_beats, n_wlast, n_bvalid;
    logic  proto_err;

    logic [31:0] lcg_q;
    int          phase, wait_cnt, gap, beat_idx;
    addr_t       cur_addr;
    len_t        cur_len;
    logic [11:0] widx;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h5a5a_0000;
    endfunction

    initial begin
        mem_rdy    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_rlast  = 1'b0;
        mem_bvalid = 1'b0;
        n_txn      = 0;
        n_beats    = 0;
        n_wlast    = 0;
        n_bvalid   = 0;
        proto_err  = 1'b0;
        phase      = 0;
        wait_cnt   = 0;
        gap        = 0;
        beat_idx   = 0;
        cur_addr   = '0;
        cur_len    = '0;
        lcg_q      = 32'h7c451715;
        for (int i = 0; i < mem_words; i++)
            mem[i] = fill_word(addr_t'(i * 4));
    end

    // responses change on the falling edge for sampling on the rising one
    always @(negedge clk) begin
        lcg_q = lcg_next(lcg_q);
        if (!arst_n) begin
            phase      = 0;
            mem_rdy    = 1'b0;
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
            mem_bvalid = 1'b0;
        end else begin
            // bready only after the last write beat
            if (mem_bready && phase != 3)
                proto_err = 1'b1;
            case (phase)
                0: begin
                    if (mem_wvalid)
                        proto_err = 1'b1;
                    if (mem_req) begin
                        if (wait_cnt == 0) begin
                            mem_rdy = 1'b1;
                            log_addr[n_txn] = mem_addr;
                            log_we[n_txn]   = mem_we;
                            log_len[n_txn]  = mem_len;
                            n_txn++;
                            cur_addr = mem_addr;
                            cur_len  = mem_len;
                            beat_idx = 0;
                            gap      = int'(lcg_q[20]);
                            phase    = mem_we ? 2 : 1;
                        end else
                            wait_cnt--;
                    end
                end
                1: begin
                    mem_rdy = 1'b0;
                    if (mem_rvalid && mem_rlast) begin
                        mem_rvalid = 1'b0;
                        mem_rlast  = 1'b0;
                        wait_cnt   = int'(lcg_q[17:16]);
                        phase      = 0;
                    end else if (gap > 0) begin
                        mem_rvalid = 1'b0;
                        gap--;
                    end else begin
                        widx       = cur_addr[13:2] + 12'(beat_idx);
                        mem_rvalid = 1'b1;
                        mem_rdata  = mem[widx];
                        mem_rlast  = beat_idx == int'(cur_len);
                        beat_idx++;
                        gap = int'(lcg_q[20]);
                    end
                end
                2: begin
                    mem_rdy = 1'b0;
                    // without a per-beat ready any gap is a protocol error
                    if (!mem_wvalid) begin
                        proto_err = 1'b1;
                    end else begin
                        widx = cur_addr[13:2] + 12'(beat_idx);
                        for (int b = 0; b < strb_w; b++) begin
                            if (mem_wstrb[b])
                                mem[widx][b*8 +: 8] = mem_wdata[b*8 +: 8];
                        end
                        beat_data[n_beats] = mem_wdata;
                        beat_strb[n_beats] = mem_wstrb;
                        n_beats++;
                        beat_idx++;
                        if (mem_wlast) begin
                            if (beat_idx != int'(cur_len) + 1)
                                proto_err = 1'b1;
                            n_wlast++;
                            phase = 3;
                        end
                    end
                end
                default: begin
                    if (mem_wvalid)
                        proto_err = 1'b1;
                    if (mem_bvalid) begin
                        mem_bvalid = 1'b0;
                        wait_cnt   = int'(lcg_q[17:16]);
                        phase      = 0;
                    end else if (gap > 0) begin
                        gap--;
                    end else if (mem_bready) begin
                        mem_bvalid = 1'b1;
                        n_bvalid++;
                    end
                end
            endcase
        end
    end

endmodule

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import mem_bus_pkg::*;

    localparam int mem_words          = 4096;
    localparam int random_requests    = 100;
    // request budget with margin over the directed and random tests
    localparam int total_requests     = 160;
    localparam int cycles_per_request = 25;
    localparam int timeout_cycles     = total_requests * cycles_per_request;

    logic  clk, arst_n, valid, op, uncache;
    addr_t addr;
    strb_t wstrb;
    word_t wdata;
    logic  ready, data_valid;
    word_t rdata;
    logic  mem_req, mem_we, mem_rdy, mem_rvalid, mem_rlast;
    addr_t mem_addr;
    len_t  mem_len;
    word_t mem_rdata, mem_wdata;
    logic  mem_wvalid, mem_wlast, mem_bready, mem_bvalid;
    strb_t mem_wstrb;

    word_t       ref_mem [mem_words];
    logic [31:0] seed;
    int          cycles = 0;
    string       test_name;

    dcache_top uut (.*);

    mem_model u_mem (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            fail_run($sformatf("run hung in test %s, no response after %0d cycles",
                               test_name, cycles));
        else if (u_mem.proto_err)
            fail_run($sformatf("memory bus protocol broken in test %s", test_name));
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // initial memory contents as a function of the byte address
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input strb_t be, input word_t d);
        word_t res;
        res = old;
        for (int b = 0; b < strb_w; b++) begin
            if (be[b])
                res[b*8 +: 8] = d[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
    endtask

    task automatic check_strb(input string what, input strb_t exp, input strb_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s %s: expected %b, actual %b",
                               test_name, what, exp, act));
    endtask

    task automatic check_len(input string what, input len_t exp, input len_t act);
        if (act !== exp)
            fail_run($sformatf("** Error %s %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
    endtask

    // starts on a falling edge and returns on the one that shows data_valid
    task automatic cpu_access(input logic st, input logic unc, input addr_t a,
                              input strb_t be, input word_t d, output word_t rd);
        valid   = 1'b1;
        op      = st;
        uncache = unc;
        addr    = a;
        wstrb   = be;
        wdata   = d;
        while (!ready)
            @(negedge clk);
        @(negedge clk);
        valid = 1'b0;
        while (!data_valid)
            @(negedge clk);
        rd = rdata;
        if (st)
            ref_mem[a[13:2]] = merge_bytes(ref_mem[a[13:2]], be, d);
    endtask

    task automatic load_check(input logic unc, input addr_t a);
        word_t rd;
        cpu_access(1'b0, unc, a, '0, '0, rd);
        check_word($sformatf("load %h", a), ref_mem[a[13:2]], rd);
    endtask

    task automatic store(input logic unc, input addr_t a, input strb_t be, input word_t d);
        word_t rd;
        cpu_access(1'b1, unc, a, be, d, rd);
    endtask

    task automatic expect_txn(input int idx, input logic we, input addr_t a, input len_t len);
        check_word("transaction direction", word_t'(we), word_t'(u_mem.log_we[idx]));
        check_addr("transaction address", a, u_mem.log_addr[idx]);
        check_len("transaction length", len, u_mem.log_len[idx]);
    endtask

    task automatic cold_read_miss();
        int n0;
        test_name = "cold_miss";
        n0 = u_mem.n_txn;
        load_check(1'b0, 32'h0000_0104);
        check_word("bus transactions", word_t'(n0 + 1), word_t'(u_mem.n_txn));
        expect_txn(n0, 1'b0, 32'h0000_0100, 2'd3);
        load_check(1'b0, 32'h0000_0108);
        check_word("bus transactions", word_t'(n0 + 1), word_t'(u_mem.n_txn));
    endtask

    task automatic store_hit_merge();
        int n0;
        test_name = "store_hit";
        n0 = u_mem.n_txn;
        store(1'b0, 32'h0000_0105, 4'b0010, 32'h0000_ab00);
        store(1'b0, 32'h0000_010a, 4'b1100, 32'hbeef_0000);
        check_word("bus transactions", word_t'(n0), word_t'(u_mem.n_txn));
        load_check(1'b0, 32'h0000_0104);
        load_check(1'b0, 32'h0000_0108);
    endtask

    task automatic dirty_eviction();
        int n0, b0;
        test_name = "dirty_evict";
        n0 = u_mem.n_txn;
        b0 = u_mem.n_beats;
        load_check(1'b0, 32'h0000_0504);
        check_word("bus transactions", word_t'(n0 + 2), word_t'(u_mem.n_txn));
        expect_txn(n0, 1'b1, 32'h0000_0100, 2'd3);
        for (int i = 0; i < 4; i++) begin
            check_word("writeback beat", ref_mem[64 + i], u_mem.beat_data[b0 + i]);
            check_strb("writeback strobe", 4'b1111, u_mem.beat_strb[b0 + i]);
        end
        expect_txn(n0 + 1, 1'b0, 32'h0000_0500, 2'd3);
    endtask

    task automatic uncached_access();
        int n0, b0;
        test_name = "uncached";
        load_check(1'b0, 32'h0000_0404);
        n0 = u_mem.n_txn;
        b0 = u_mem.n_beats;
        store(1'b1, 32'h0000_2008, 4'b0110, 32'h00c3_d200);
        expect_txn(n0, 1'b1, 32'h0000_2008, 2'd0);
        check_strb("uncached strobe", 4'b0110, u_mem.beat_strb[b0]);
        check_word("uncached beat", 32'h00c3_d200, u_mem.beat_data[b0]);
        load_check(1'b1, 32'h0000_2008);
        load_check(1'b1, 32'h0000_2008);
        expect_txn(n0 + 1, 1'b0, 32'h0000_2008, 2'd0);
        expect_txn(n0 + 2, 1'b0, 32'h0000_2008, 2'd0);
        // uncached read of a resident line leaves the cached copy alone
        load_check(1'b1, 32'h0000_0408);
        expect_txn(n0 + 3, 1'b0, 32'h0000_0408, 2'd0);
        load_check(1'b0, 32'h0000_0408);
        check_word("bus transactions", word_t'(n0 + 4), word_t'(u_mem.n_txn));
    endtask

    task automatic random_traffic();
        addr_t a;
        strb_t be;
        logic  unc;
        test_name = "random";
        for (int i = 0; i < random_requests; i++) begin
            seed = lcg_next(seed);
            // uncached traffic above 0x2000 never aliases a cached line
            unc = seed[30];
            a   = {19'b0, seed[12:2], 2'b00} | (unc ? 32'h0000_2000 : 32'h0);
            be  = seed[19:16] == 4'b0 ? 4'b1111 : seed[19:16];
            if (seed[31]) begin
                seed = lcg_next(seed);
                store(unc, a, be, seed);
            end else
                load_check(unc, a);
        end
        check_word("bvalid count", word_t'(u_mem.n_wlast), word_t'(u_mem.n_bvalid));
    endtask

    initial begin
        arst_n  = 1'b0;
        valid   = 1'b0;
        op      = 1'b0;
        uncache = 1'b0;
        addr    = '0;
        wstrb   = '0;
        wdata   = '0;
        seed    = 32'h7c451715;
        test_name = "reset";
        for (int i = 0; i < mem_words; i++)
            ref_mem[i] = fill_word(addr_t'(i * 4));
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_word("idle outputs", 32'h10,
                   word_t'({ready, data_valid, mem_req, mem_wvalid, mem_bready}));
        cold_read_miss();
        store_hit_merge();
        dirty_eviction();
        uncached_access();
        random_traffic();
        if (u_mem.proto_err) begin
            fail_run("memory bus protocol broken, write beats or bready misplaced");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== build.f ====
hdl/mem_bus_pkg.sv
hdl/dcache_pkg.sv
hdl/mem_bus_if.sv
hdl/bus_arbiter.sv
hdl/line_fill_unit.sv
hdl/victim_writer.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
